// ==== source/cpuConfigPkg.sv ====
package cpuConfigPkg;

    ////////////////////////////////////////
    // Memory-side sizing
    ////////////////////////////////////////

    localparam int QueueDepth = 4;    // Load/store queue entries
    localparam int RamBytes   = 1024; // Data RAM size in bytes

endpackage

// ==== source/memTypesPkg.sv ====
package memTypesPkg;

    ////////////////////////////////////////
    // Datapath vectors
    ////////////////////////////////////////

    typedef logic [31:0] addrT; // Byte address
    typedef logic [31:0] dataT; // Data word
    typedef logic [7:0]  byteT; // One memory byte
    typedef logic [1:0]  lenT;  // Access bytes minus one (0, 1 or 3)
    typedef logic [3:0]  tagT;  // Issuing instruction tag

    ////////////////////////////////////////
    // Memory controller FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlBusy,
        ctrlDone
    } ctrlStateT;

endpackage

// ==== source/loadStoreQueue.sv ====
`timescale 1ns/1ps

module loadStoreQueue #(
    parameter int depth = cpuConfigPkg::QueueDepth
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              issueEn,
    input  logic              issueLs,
    input  memTypesPkg::addrT issueAddr,
    input  memTypesPkg::dataT issueData,
    input  memTypesPkg::lenT  issueLen,
    input  memTypesPkg::tagT  issueTag,
    output logic              queueFull,

    input  logic              cacheFree,
    output logic              reqEn,
    output logic              reqLs,
    output memTypesPkg::addrT reqAddr,
    output memTypesPkg::dataT reqData,
    output memTypesPkg::lenT  reqLen,
    output memTypesPkg::tagT  reqTag
);
    import memTypesPkg::*;

    localparam int ptrW = $clog2(depth);
    localparam int cntW = $clog2(depth + 1);

    logic             lsQ   [depth];
    addrT             addrQ [depth];
    dataT             dataQ [depth];
    lenT              lenQ  [depth];
    tagT              tagQ  [depth];

    logic [ptrW-1:0]  head;
    logic [ptrW-1:0]  tail;
    logic [cntW-1:0]  count;
    logic             push;

    assign queueFull = (count == cntW'(depth));
    assign push      = issueEn && !queueFull; // Strobes while full are dropped
    assign reqEn     = (count != '0) && cacheFree;

    assign reqLs   = lsQ[head];
    assign reqAddr = addrQ[head];
    assign reqData = dataQ[head];
    assign reqLen  = lenQ[head];
    assign reqTag  = tagQ[head];

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                tail <= (tail == ptrW'(depth - 1)) ? '0 : tail + 1'b1; // Wrap for any depth
            end
            if (reqEn) begin
                head <= (head == ptrW'(depth - 1)) ? '0 : head + 1'b1;
            end
            case ({push, reqEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && push) begin
            lsQ[tail]   <= issueLs;
            addrQ[tail] <= issueAddr;
            dataQ[tail] <= issueData;
            lenQ[tail]  <= issueLen;
            tagQ[tail]  <= issueTag;
        end
    end

endmodule

// ==== source/dataCache.sv ====
`timescale 1ns/1ps

module dataCache (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              reqEn,
    input  logic              reqLs,
    input  memTypesPkg::addrT reqAddr,
    input  memTypesPkg::dataT reqData,
    input  memTypesPkg::lenT  reqLen,
    input  memTypesPkg::tagT  reqTag,
    output logic              cacheFree,

    input  logic              memWait,
    output logic              memEn,
    output logic              memLs,
    output memTypesPkg::addrT memAddr,
    output memTypesPkg::dataT memData,
    output memTypesPkg::lenT  memLen,
    input  logic              memDone,
    input  memTypesPkg::dataT memRdata,

    output logic              doneEn,
    output memTypesPkg::dataT doneData,
    output memTypesPkg::tagT  doneTag
);
    import memTypesPkg::*;

    logic occupied; // Entry holds an operation
    logic sent;     // Entry already handed to the controller
    logic holdLs;
    addrT holdAddr;
    dataT holdData;
    lenT  holdLen;
    tagT  holdTag;

    assign cacheFree = !rst && rdy && !occupied;
    assign memEn     = occupied && !sent && !memWait && rdy;
    assign memLs     = holdLs;
    assign memAddr   = holdAddr;
    assign memData   = holdData;
    assign memLen    = holdLen;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            sent     <= 1'b0;
            doneEn   <= 1'b0;
        end else if (rdy) begin
            doneEn <= memDone; // Result returns one cycle after the controller
            if (reqEn) begin
                occupied <= 1'b1;
                sent     <= 1'b0;
            end
            if (memEn) begin
                sent <= 1'b1;
            end
            if (memDone) begin
                occupied <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (reqEn) begin
                holdLs   <= reqLs;
                holdAddr <= reqAddr;
                holdData <= reqData;
                holdLen  <= reqLen;
                holdTag  <= reqTag;
            end
            if (memDone) begin
                doneData <= memRdata;
                doneTag  <= holdTag;
            end
        end
    end

endmodule

// ==== source/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              fetchHold,

    input  logic              memEn,
    input  logic              memLs,
    input  memTypesPkg::addrT memAddr,
    input  memTypesPkg::dataT memData,
    input  memTypesPkg::lenT  memLen,
    output logic              memWait,
    output logic              memDone,
    output memTypesPkg::dataT memRdata,

    output logic              ramWe,
    output memTypesPkg::addrT ramAddr,
    output memTypesPkg::byteT ramWdata,
    input  memTypesPkg::byteT ramRdata
);
    import memTypesPkg::*;

    ctrlStateT  state;
    logic       isStore;
    addrT       baseAddr;
    dataT       wrData;
    lenT        lenReg;
    logic [2:0] byteIdx;   // Bytes addressed so far
    dataT       rdData;    // Load bytes gathered so far
    addrT       lastAddr;  // Address presented in the last running cycle
    addrT       curAddr;
    logic       accessNow;
    logic [1:0] readSlot;
    dataT       assembled;

    assign memWait = fetchHold || (state != ctrlIdle);
    assign memDone = (state == ctrlDone);

    ////////////////////////////////////////
    // RAM access, first byte on memEn
    ////////////////////////////////////////

    assign accessNow = ((state == ctrlIdle) && memEn) ||
                       ((state == ctrlBusy) && (byteIdx <= {1'b0, lenReg}));
    assign curAddr   = (state == ctrlIdle) ? memAddr : baseAddr + addrT'(byteIdx);
    assign ramAddr   = rdy ? curAddr : lastAddr; // Hold read data aligned while frozen
    assign ramWe     = rdy && accessNow && ((state == ctrlIdle) ? memLs : isStore);
    assign ramWdata  = (state == ctrlIdle) ? memData[7:0] : wrData[8*byteIdx[1:0] +: 8];

    // Byte on ramRdata was addressed one cycle earlier
    assign readSlot = byteIdx[1:0] - 2'd1;

    always_comb begin
        assembled                   = rdData;
        assembled[8*readSlot +: 8]  = ramRdata;
    end

    ////////////////////////////////////////
    // Access FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrlIdle;
        end else if (rdy) begin
            case (state)
                ctrlIdle: if (memEn) state <= ctrlBusy;
                ctrlBusy: if (byteIdx == {1'b0, lenReg} + 3'd1) state <= ctrlDone;
                default:  state <= ctrlIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            lastAddr <= curAddr;
            if (state == ctrlIdle && memEn) begin
                isStore  <= memLs;
                baseAddr <= memAddr;
                wrData   <= memData;
                lenReg   <= memLen;
                byteIdx  <= 3'd1;
                rdData   <= '0; // Loads are zero-extended
            end else if (state == ctrlBusy) begin
                byteIdx <= byteIdx + 3'd1;
                if (!isStore) begin
                    rdData <= assembled;
                end
                if (byteIdx == {1'b0, lenReg} + 3'd1) begin
                    memRdata <= isStore ? '0 : assembled;
                end
            end
        end
    end

endmodule

// ==== source/dataRam.sv ====
`timescale 1ns/1ps

module dataRam #(
    parameter int bytes = cpuConfigPkg::RamBytes
) (
    input  logic              clk,
    input  logic              ramWe,
    input  memTypesPkg::addrT ramAddr,
    input  memTypesPkg::byteT ramWdata,
    output memTypesPkg::byteT ramRdata
);
    import memTypesPkg::*;

    localparam int slotW = $clog2(bytes);

    byteT             mem [bytes] = '{default: '0};
    logic [slotW-1:0] slot;

    assign slot = slotW'(ramAddr % addrT'(bytes)); // Wraps past the top

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[slot] <= ramWdata;
        end
        ramRdata <= mem[slot]; // One cycle read latency
    end

endmodule

// ==== source/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem #(
    parameter int queueDepth = cpuConfigPkg::QueueDepth,
    parameter int ramBytes   = cpuConfigPkg::RamBytes
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              fetchHold,

    input  logic              issueEn,
    input  logic              issueLs,
    input  memTypesPkg::addrT issueAddr,
    input  memTypesPkg::dataT issueData,
    input  memTypesPkg::lenT  issueLen,
    input  memTypesPkg::tagT  issueTag,
    output logic              queueFull,

    output logic              doneEn,
    output memTypesPkg::dataT doneData,
    output memTypesPkg::tagT  doneTag
);
    import memTypesPkg::*;

    ////////////////////////////////////////
    // Queue to cache
    ////////////////////////////////////////

    logic cacheFree;
    logic reqEn;
    logic reqLs;
    addrT reqAddr;
    dataT reqData;
    lenT  reqLen;
    tagT  reqTag;

    ////////////////////////////////////////
    // Cache to controller to RAM
    ////////////////////////////////////////

    logic memWait;
    logic memEn;
    logic memLs;
    addrT memAddr;
    dataT memData;
    lenT  memLen;
    logic memDone;
    dataT memRdata;
    logic ramWe;
    addrT ramAddr;
    byteT ramWdata;
    byteT ramRdata;

    loadStoreQueue #(
        .depth(queueDepth)
    ) loadStoreQueue_i (
        .clk, .rst, .rdy,
        .issueEn, .issueLs, .issueAddr, .issueData, .issueLen, .issueTag, .queueFull,
        .cacheFree, .reqEn, .reqLs, .reqAddr, .reqData, .reqLen, .reqTag
    );

    dataCache dataCache_i (
        .clk, .rst, .rdy,
        .reqEn, .reqLs, .reqAddr, .reqData, .reqLen, .reqTag, .cacheFree,
        .memWait, .memEn, .memLs, .memAddr, .memData, .memLen, .memDone, .memRdata,
        .doneEn, .doneData, .doneTag
    );

    memCtrl memCtrl_i (
        .clk, .rst, .rdy, .fetchHold,
        .memEn, .memLs, .memAddr, .memData, .memLen, .memWait, .memDone, .memRdata,
        .ramWe, .ramAddr, .ramWdata, .ramRdata
    );

    dataRam #(
        .bytes(ramBytes)
    ) dataRam_i (
        .clk, .ramWe, .ramAddr, .ramWdata, .ramRdata
    );

endmodule

// ==== test/memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb;
    import memTypesPkg::*;
    import cpuConfigPkg::*;

    localparam int waitLimit = 400; // Cycles allowed for any single wait

    logic clk;
    logic rst;
    logic rdy;
    logic fetchHold;
    logic issueEn;
    logic issueLs;
    addrT issueAddr;
    dataT issueData;
    lenT  issueLen;
    tagT  issueTag;
    logic queueFull;
    logic doneEn;
    dataT doneData;
    tagT  doneTag;

    byteT        model [RamBytes];
    dataT        expData [$];
    tagT         expTag [$];
    logic [31:0] lfsr = 32'h532f_7a11;
    tagT         nextTag;
    logic        hung;
    int          errors;
    int          testErrors;
    int          testCount;
    int          doneCount;
    int          k;

    memSubsystem #(
        .queueDepth(QueueDepth),
        .ramBytes(RamBytes)
    ) memSubsystem_i (
        .clk, .rst, .rdy, .fetchHold,
        .issueEn, .issueLs, .issueAddr, .issueData, .issueLen, .issueTag, .queueFull,
        .doneEn, .doneData, .doneTag
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source and checks
    ////////////////////////////////////////

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // Galois step
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            $display("Error %s got %h expected %h", name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkTag(input string name, input tagT got, input tagT exp);
        if (got !== exp) begin
            $display("Error %s got %h expected %h", name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %s got %h expected %h", name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && rdy && doneEn) begin // A frozen pulse is taken once
            if (expData.size() == 0) begin
                $display("A result with tag %h came back with nothing outstanding", doneTag);
                errors++;
                testErrors++;
            end else begin
                checkData("doneData", doneData, expData.pop_front());
                checkTag("doneTag", doneTag, expTag.pop_front());
            end
            doneCount++;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic issueOp(input logic ls, input addrT addr, input dataT data, input lenT len);
        dataT exp;
        int   guard;
        int   idx;
        exp   = '0;
        guard = 0;
        while (queueFull && !hung) begin
            if (guard == waitLimit) begin
                $display("Timed out waiting for the queue to accept an operation");
                hung = 1'b1;
            end else begin
                guard++;
                nextCycle();
            end
        end
        if (!hung) begin
            for (int i = 0; i <= int'(len); i++) begin
                idx = int'((addr + addrT'(i)) % addrT'(RamBytes)); // Little-endian, wraps
                if (ls) model[idx] = data[8*i +: 8];
                else    exp[8*i +: 8] = model[idx];
            end
            expData.push_back(exp); // Stores return zero
            expTag.push_back(nextTag);
            issueEn   = 1'b1;
            issueLs   = ls;
            issueAddr = addr;
            issueData = data;
            issueLen  = len;
            issueTag  = nextTag;
            nextTag++;
            nextCycle();
            issueEn = 1'b0;
        end
    endtask

    task automatic issueRandom(input int addrBits);
        logic ls;
        addrT addr;
        dataT data;
        lenT  len;
        logic [31:0] sel;
        ls   = randomBits(1) != 0;
        addr = randomBits(addrBits);
        data = randomBits(32);
        sel  = randomBits(2);
        len  = sel[1] ? lenT'(3) : lenT'(sel[0]); // Codes 0, 1 and 3 only
        issueOp(ls, addr, data, len);
    endtask

    task automatic waitDrain(input string what);
        int guard;
        guard = 0;
        while (expData.size() != 0 && !hung) begin
            if (guard == waitLimit) begin
                $display("Timed out with %0d results missing in %s", expData.size(), what);
                hung = 1'b1;
            end else begin
                guard++;
                nextCycle();
            end
        end
    endtask

    // No new result may show up while the path is held
    task automatic holdCheck(input int cycles, input string what);
        int   startCount;
        logic startDone;
        logic moved;
        startCount = doneCount;
        startDone  = doneEn;
        moved      = 1'b0;
        repeat (cycles) begin
            nextCycle();
            if (doneCount != startCount || doneEn !== startDone) moved = 1'b1;
        end
        if (moved) begin
            $display("A result came back while %s", what);
            errors++;
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("%s finished with %0d errors", name, testErrors);
        testErrors = 0;
    endtask

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        fetchHold = 1'b0;
        issueEn = 1'b0;
        issueLs = 1'b0;
        issueAddr = '0;
        issueData = '0;
        issueLen = '0;
        issueTag = '0;
        nextTag = '0;
        hung = 1'b0;
        errors = 0;
        testErrors = 0;
        testCount = 0;
        doneCount = 0;
        foreach (model[i]) model[i] = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        checkFlag("queueFull", queueFull, 1'b0);
        checkFlag("doneEn", doneEn, 1'b0);

        issueOp(1'b1, addrT'(randomBits(10)), randomBits(32), lenT'(3));
        issueOp(1'b0, issueAddr, '0, lenT'(3)); // Same address as the store
        waitDrain("store then load");
        endTest("Store then load");

        for (k = 0; k < 3; k++) begin
            issueOp(1'b1, addrT'(randomBits(10)), randomBits(32), (k == 2) ? lenT'(3) : lenT'(k));
            issueOp(1'b0, issueAddr, '0, issueLen);
            issueOp(1'b0, issueAddr, '0, lenT'(3)); // Bytes past the store stay intact
        end
        waitDrain("lengths");
        endTest("Lengths");

        repeat (200) issueRandom(6);
        waitDrain("random stream");
        endTest("Random stream");

        fetchHold = 1'b1;
        issueRandom(6);
        holdCheck(30, "fetchHold was high");
        fetchHold = 1'b0;
        waitDrain("fetchHold stall");
        endTest("fetchHold stall");

        fetchHold = 1'b1;
        for (k = 0; k <= QueueDepth; k++) issueRandom(6);
        checkFlag("queueFull", queueFull, 1'b1);
        issueEn  = 1'b1; // A strobe into a full queue is dropped
        issueTag = nextTag + 4'd8;
        nextCycle();
        issueEn = 1'b0;
        checkFlag("queueFull", queueFull, 1'b1);
        holdCheck(10, "fetchHold was high with a full queue");
        fetchHold = 1'b0;
        waitDrain("back-pressure");
        endTest("Back-pressure");

        repeat (3) issueRandom(6);
        rdy = 1'b0;
        holdCheck(20, "rdy was low");
        rdy = 1'b1;
        waitDrain("rdy freeze");
        endTest("rdy freeze");

        $display("%0d tests, %0d results, %0d errors", testCount, doneCount, errors);
        if (errors == 0 && !hung) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/cpuConfigPkg.sv
source/memTypesPkg.sv
source/loadStoreQueue.sv
source/dataCache.sv
source/memCtrl.sv
source/dataRam.sv
source/memSubsystem.sv
test/memSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module memSubsystemTb -f sources.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
